//--- Bender.yml
package:
  name: md_unit

sources:
  - rtl/md_isa_pkg.sv
  - rtl/md_ctrl_pkg.sv
  - rtl/md_lane_if.sv
  - rtl/mul_seq.sv
  - rtl/div_seq.sv
  - rtl/md_combine.sv
  - rtl/md_unit.sv
  - target: test
    files:
      - dv/md_unit_sva.sv
      - dv/md_unit_tb.sv

//--- all.f
rtl/md_isa_pkg.sv
rtl/md_ctrl_pkg.sv
rtl/md_lane_if.sv
rtl/mul_seq.sv
rtl/div_seq.sv
rtl/md_combine.sv
rtl/md_unit.sv
dv/md_unit_sva.sv
dv/md_unit_tb.sv

//--- dv/md_cases.txt
# opcode a b exp_a exp_b exp_ov accept, all hex
# accept 0 at the top goes in while idle, later ones while the case above is busy
A5 10 10 00 00 0 0
85 03 03 00 00 0 0
A4 00 37 00 00 0 1
A4 0C 00 00 00 0 1
A4 07 09 3F 00 0 1
84 50 05 00 00 0 0
A4 FF FF 01 FE 1 1
A4 10 20 00 02 1 1
84 64 07 0E 02 0 1
33 01 01 00 00 0 0
84 05 09 00 05 0 1
84 C8 01 C8 00 0 1
84 5A 00 FF 5A 1 1
84 00 00 FF 00 1 1

//--- dv/md_unit_sva.sv
`timescale 1ns/1ps

// controller protocol checks, bound into md_combine
module md_unit_sva import md_ctrl_pkg::*; (
   input logic        i_clk,
   input logic        i_nrst,
   input ctrl_state_e state,
   input logic        go_div,
   input logic        mul_start,
   input logic        div_start,
   input logic        o_busy,
   input logic        o_done
);

   // done is a single-cycle pulse
   a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_done |=> !o_done)
      else $error("o_done held high for more than one cycle");

   a_idle_at_done: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_done |-> $fell(o_busy))   // done closes a busy period
      else $error("o_done came without the end of a busy period");

   // a lane strobe only follows an idle controller
   a_start_idle: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (mul_start || div_start) |-> ($past(state) == C_IDLE) && (state != C_IDLE))
      else $error("lane start issued while the controller is not idle");

   ////////////////////
   // fixed divider latency

   a_div_latency: assert property (@(posedge i_clk) disable iff (!i_nrst)
      go_div |-> ##(DIV_STEPS + 4) o_done)
      else $error("divide result did not arrive on its fixed cycle");

endmodule

bind md_combine md_unit_sva sva0 (
   .i_clk     (i_clk),
   .i_nrst    (i_nrst),
   .state     (state),
   .go_div    (go_div),
   .mul_start (mul_lane.start),
   .div_start (div_lane.start),
   .o_busy    (o_busy),
   .o_done    (o_done)
);

//--- dv/md_unit_tb.sv
`timescale 1ns/1ps

module md_unit_tb import md_isa_pkg::*; ();

   localparam int CLK_HALF     = 4;     // 8 ns period
   localparam int QUIET_CYC    = 12;    // idle cycles watched after each case
   localparam int CYC_PER_CASE = 270;

   logic  i_clk;
   logic  i_nrst;
   logic  i_start;
   byte_t i_opcode;
   byte_t i_a;
   byte_t i_b;
   logic  o_busy;
   logic  o_done;
   byte_t o_a;
   byte_t o_b;
   logic  o_ov;

   // case table from the data file
   byte_t c_op[$];
   byte_t c_a[$];
   byte_t c_b[$];
   byte_t c_ea[$];
   byte_t c_eb[$];
   logic  c_eov[$];
   logic  c_acc[$];

   byte_t last_a;    // outputs of the latest accepted case
   byte_t last_b;
   logic  last_ov;
   int    cycles = 0;
   int    limit = 0;

   md_unit dut0 (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_start  (i_start),
      .i_opcode (i_opcode),
      .i_a      (i_a),
      .i_b      (i_b),
      .o_busy   (o_busy),
      .o_done   (o_done),
      .o_a      (o_a),
      .o_b      (o_b),
      .o_ov     (o_ov)
   );

   initial begin
      i_clk = 1'b0;
      forever #CLK_HALF i_clk = ~i_clk;
   end

   ////////////////////
   // helpers

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("error: %s is %h, expected %h", name, got, exp));
      end
   endtask

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         abort_run($sformatf("timeout: o_done never came within %0d cycles", limit));
      end
   end

   task automatic load_cases();
      int         fd;
      int         cnt;
      string      line;
      logic [7:0] f_op;
      logic [7:0] f_a;
      logic [7:0] f_b;
      logic [7:0] f_ea;
      logic [7:0] f_eb;
      logic [7:0] f_ov;
      logic [7:0] f_acc;
      fd = $fopen("dv/md_cases.txt", "r");
      if (fd == 0) begin
         abort_run("could not open dv/md_cases.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         cnt = $fgets(line, fd);
         if (line.len() > 0 && line[0] != "#") begin   // skip the column notes
            cnt = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_a, f_b, f_ea, f_eb, f_ov, f_acc);
            if (cnt == 7) begin
               c_op.push_back(f_op);
               c_a.push_back(f_a);
               c_b.push_back(f_b);
               c_ea.push_back(f_ea);
               c_eb.push_back(f_eb);
               c_eov.push_back(f_ov[0]);
               c_acc.push_back(f_acc[0]);
            end
         end
      end
      $fclose(fd);
      if (c_op.size() == 0) begin
         abort_run("no cases found in dv/md_cases.txt");
      end
   endtask

   task automatic drive_inputs(input logic s, input byte_t op, input byte_t a, input byte_t b);
      i_start  = s;
      i_opcode = op;
      i_a      = a;
      i_b      = b;
   endtask

   // no done, not busy, results untouched
   task automatic hold_quiet();
      repeat (QUIET_CYC) begin
         @(posedge i_clk);
         #1;
         check("o_done", o_done, 1'b0);
         check("o_busy", o_busy, 1'b0);
         check("o_a", o_a, last_a);
         check("o_b", o_b, last_b);
         check("o_ov", o_ov, last_ov);
      end
   endtask

   ////////////////////
   // case runners

   task automatic try_idle_start(input int idx);
      check("o_busy", o_busy, 1'b0);
      drive_inputs(1'b1, c_op[idx], c_a[idx], c_b[idx]);
      @(posedge i_clk);
      #1;
      i_start = 1'b0;
      hold_quiet();
   endtask

   // following accept-0 lines are pushed in while this case is busy
   task automatic run_case(input int idx, output int next);
      int j;
      int lat;
      int exp_lat;
      j = idx + 1;
      lat = 0;
      check("o_busy", o_busy, 1'b0);
      drive_inputs(1'b1, c_op[idx], c_a[idx], c_b[idx]);
      @(posedge i_clk);   // cycle 0
      #1;
      while (o_done !== 1'b1) begin
         // busy all the way, earlier results still held
         check("o_busy", o_busy, 1'b1);
         check("o_a", o_a, last_a);
         check("o_b", o_b, last_b);
         check("o_ov", o_ov, last_ov);
         if (j < c_op.size() && c_acc[j] == 1'b0) begin
            drive_inputs(1'b1, c_op[j], c_a[j], c_b[j]);
            j++;
         end else begin
            i_start = 1'b0;
         end
         @(posedge i_clk);
         #1;
         lat++;
      end
      i_start = 1'b0;
      exp_lat = (c_op[idx] == OP_MUL) ? int'(c_a[idx]) + 3 : 11;
      check("o_done latency", lat, exp_lat);
      check("o_a", o_a, c_ea[idx]);
      check("o_b", o_b, c_eb[idx]);
      check("o_ov", o_ov, c_eov[idx]);
      last_a  = c_ea[idx];
      last_b  = c_eb[idx];
      last_ov = c_eov[idx];
      hold_quiet();
      next = j;
   endtask

   ////////////////////
   // main sequence

   initial begin
      int i;
      int nxt;
      i_nrst = 1'b0;
      drive_inputs(1'b0, '0, '0, '0);
      last_a  = '0;
      last_b  = '0;
      last_ov = 1'b0;
      load_cases();
      limit = c_op.size() * CYC_PER_CASE + 50;
      repeat (3) @(posedge i_clk);
      #1;
      i_nrst = 1'b1;
      // outputs straight out of reset
      check("o_busy", o_busy, 1'b0);
      check("o_done", o_done, 1'b0);
      check("o_a", o_a, 8'h00);
      check("o_b", o_b, 8'h00);
      check("o_ov", o_ov, 1'b0);
      i = 0;
      while (i < c_op.size()) begin
         if (c_acc[i]) begin
            run_case(i, nxt);
            i = nxt;
         end else begin
            try_idle_start(i);
            i++;
         end
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- rtl/div_seq.sv
`timescale 1ns/1ps

// restoring divider, msb of the dividend first
module div_seq import md_isa_pkg::*, md_ctrl_pkg::*; (
   md_lane_if.eng lane,
   input  logic   i_clk,
   input  logic   i_nrst
);

   logic            run;       // steps or final pulse pending
   step_cnt_t       cnt;       // steps left
   logic            last;
   byte_t           dvd;       // dividend shifter
   byte_t           dvs;       // divisor copy
   byte_t           quo;       // quotient, filled from the lsb
   logic [BYTE_W:0] rem;       // partial remainder
   logic [BYTE_W:0] shifted;
   logic            fits;      // shifted remainder >= divisor

   assign last = (cnt == '0);

   ////////////////////
   // one restoring step

   // next dividend bit enters at the bottom
   assign shifted = {rem[BYTE_W-1:0], dvd[BYTE_W-1]};
   assign fits    = (shifted >= {1'b0, dvs});   // always true for b == 0

   ////////////////////
   // control

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         run       <= 1'b0;
         cnt       <= '0;
         lane.done <= 1'b0;
      end else begin
         lane.done <= run & last;
         if (lane.start) begin
            run <= 1'b1;
            cnt <= step_cnt_t'(DIV_STEPS);
         end else if (run) begin
            if (last) begin
               run <= 1'b0;
            end else begin
               cnt <= cnt - 1'b1;
            end
         end
      end
   end

   ////////////////////
   // datapath

   always_ff @(posedge i_clk) begin
      if (lane.start) begin
         dvd <= lane.a;
         dvs <= lane.b;
         rem <= '0;
         quo <= '0;
      end else if (run && !last) begin
         dvd <= {dvd[BYTE_W-2:0], 1'b0};
         quo <= {quo[BYTE_W-2:0], fits};
         if (fits) begin
            rem <= shifted - {1'b0, dvs};   // subtract and keep
         end else begin
            rem <= shifted;                 // restore
         end
      end
   end

   // remainder is below the divisor here, the top bit is clear
   assign lane.lo = quo;
   assign lane.hi = rem[BYTE_W-1:0];

endmodule

//--- rtl/md_combine.sv
`timescale 1ns/1ps

// picks the engine, collects its result and forms ov
module md_combine import md_isa_pkg::*, md_ctrl_pkg::*; (
   input  logic    i_clk,
   input  logic    i_nrst,
   input  logic    i_start,
   input  byte_t   i_opcode,
   input  byte_t   i_a,
   input  byte_t   i_b,
   md_lane_if.ctrl mul_lane,
   md_lane_if.ctrl div_lane,
   output logic    o_busy,
   output logic    o_done,
   output byte_t   o_a,
   output byte_t   o_b,
   output logic    o_ov
);

   ctrl_state_e state;
   ctrl_state_e state_nxt;
   opcode_e     op;
   logic        go_mul;     // accepted mul start
   logic        go_div;     // accepted div start
   logic        fin;        // active lane reports done
   byte_t       opa;
   byte_t       opb;        // also the divisor for the zero test
   byte_t       res_lo;
   byte_t       res_hi;
   logic        res_ov;

   ////////////////////
   // decode

   assign op     = opcode_e'(i_opcode);
   assign go_mul = i_start & (state == C_IDLE) & (op == OP_MUL);
   assign go_div = i_start & (state == C_IDLE) & (op == OP_DIV);

   always_comb begin
      state_nxt = state;
      case (state)
         C_IDLE: begin
            if (go_mul) begin
               state_nxt = C_MUL;
            end else if (go_div) begin
               state_nxt = C_DIV;
            end
         end
         C_MUL: begin
            if (mul_lane.done) begin
               state_nxt = C_IDLE;
            end
         end
         C_DIV: begin
            if (div_lane.done) begin
               state_nxt = C_IDLE;
            end
         end
         default: state_nxt = C_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state          <= C_IDLE;
         mul_lane.start <= 1'b0;
         div_lane.start <= 1'b0;
      end else begin
         state          <= state_nxt;
         mul_lane.start <= go_mul;   // single-cycle pulses
         div_lane.start <= go_div;
      end
   end

   // operands latched with the accepted start
   always_ff @(posedge i_clk) begin
      if (go_mul || go_div) begin
         opa <= i_a;
         opb <= i_b;
      end
   end

   assign mul_lane.a = opa;
   assign mul_lane.b = opb;
   assign div_lane.a = opa;
   assign div_lane.b = opb;

   ////////////////////
   // result

   assign fin    = ((state == C_MUL) & mul_lane.done) |
                   ((state == C_DIV) & div_lane.done);
   assign res_lo = (state == C_MUL) ? mul_lane.lo : div_lane.lo;
   assign res_hi = (state == C_MUL) ? mul_lane.hi : div_lane.hi;
   // mul overflows into b, div flags a zero divisor
   assign res_ov = (state == C_MUL) ? (mul_lane.hi != {BYTE_W{1'b0}})
                                    : (opb == {BYTE_W{1'b0}});

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_done <= 1'b0;
         o_a    <= '0;
         o_b    <= '0;
         o_ov   <= 1'b0;
      end else begin
         o_done <= fin;
         if (fin) begin
            o_a  <= res_lo;   // acc
            o_b  <= res_hi;   // b register
            o_ov <= res_ov;
         end
      end
   end

   assign o_busy = (state != C_IDLE);

endmodule

//--- rtl/md_ctrl_pkg.sv
package md_ctrl_pkg;

   ////////////////////
   // controller states

   typedef enum logic [1:0] {
      C_IDLE,   // waiting for a start
      C_MUL,    // multiplier lane active
      C_DIV     // divider lane active
   } ctrl_state_e;

   ////////////////////
   // engine timing

   // restoring divider produces one quotient bit per step
   localparam int DIV_STEPS = 8;

   // counts DIV_STEPS down to zero
   typedef logic [$clog2(DIV_STEPS+1)-1:0] step_cnt_t;

endpackage

//--- rtl/md_isa_pkg.sv
package md_isa_pkg;

   ////////////////////
   // widths

   localparam int BYTE_W = 8;   // operand and result width

   typedef logic [BYTE_W-1:0] byte_t;

   ////////////////////
   // opcodes

   // only the two multi-cycle ALU ops of the core
   typedef enum logic [BYTE_W-1:0] {
      OP_DIV = 8'h84,   // div ab
      OP_MUL = 8'hA4    // mul ab
   } opcode_e;

endpackage

//--- rtl/md_lane_if.sv
`timescale 1ns/1ps

interface md_lane_if import md_isa_pkg::*; ();

   logic  start;   // one-cycle request from the controller
   byte_t a;       // stable while start is high
   byte_t b;
   logic  done;    // one-cycle completion pulse
   byte_t lo;      // valid while done is high
   byte_t hi;

   // controller side
   modport ctrl (
      output start,
      output a,
      output b,
      input  done,
      input  lo,
      input  hi
   );

   // engine side
   modport eng (
      input  start,
      input  a,
      input  b,
      output done,
      output lo,
      output hi
   );

endinterface

//--- rtl/md_unit.sv
`timescale 1ns/1ps

module md_unit import md_isa_pkg::*; (
   input  logic              i_clk,
   input  logic              i_nrst,
   input  logic              i_start,
   input  logic [BYTE_W-1:0] i_opcode,
   input  logic [BYTE_W-1:0] i_a,
   input  logic [BYTE_W-1:0] i_b,
   output logic              o_busy,
   output logic              o_done,
   output logic [BYTE_W-1:0] o_a,
   output logic [BYTE_W-1:0] o_b,
   output logic              o_ov
);

   md_lane_if mul_lane ();
   md_lane_if div_lane ();

   ////////////////////
   // engines

   mul_seq mul0 (
      .lane   (mul_lane.eng),
      .i_clk  (i_clk),
      .i_nrst (i_nrst)
   );

   div_seq div0 (
      .lane   (div_lane.eng),
      .i_clk  (i_clk),
      .i_nrst (i_nrst)
   );

   ////////////////////
   // controller

   md_combine ctrl0 (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_start  (i_start),
      .i_opcode (i_opcode),
      .i_a      (i_a),
      .i_b      (i_b),
      .mul_lane (mul_lane.ctrl),
      .div_lane (div_lane.ctrl),
      .o_busy   (o_busy),
      .o_done   (o_done),
      .o_a      (o_a),
      .o_b      (o_b),
      .o_ov     (o_ov)
   );

endmodule

//--- rtl/mul_seq.sv
`timescale 1ns/1ps

// repeated addition, b is added once per count of a
module mul_seq import md_isa_pkg::*; (
   md_lane_if.eng lane,
   input  logic   i_clk,
   input  logic   i_nrst
);

   logic                run;        // sequence in flight
   byte_t               cnt;        // additions still to do
   logic                cnt_zero;
   byte_t               mcand;      // copy of b
   logic [2*BYTE_W-1:0] sum;        // running product

   assign cnt_zero = (cnt == '0);

   ////////////////////
   // control

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         run       <= 1'b0;
         cnt       <= '0;
         lane.done <= 1'b0;
      end else begin
         lane.done <= run & cnt_zero;   // a == 0 ends right away
         if (lane.start) begin
            run <= 1'b1;
            cnt <= lane.a;
         end else if (run) begin
            if (cnt_zero) begin
               run <= 1'b0;
            end else begin
               cnt <= cnt - 1'b1;
            end
         end
      end
   end

   ////////////////////
   // datapath

   always_ff @(posedge i_clk) begin
      if (lane.start) begin
         sum   <= '0;
         mcand <= lane.b;
      end else if (run && !cnt_zero) begin
         // zero-extend b to the product width
         sum <= sum + {{BYTE_W{1'b0}}, mcand};
      end
   end

   // sum is left alone once the count runs out
   assign lane.lo = sum[BYTE_W-1:0];
   assign lane.hi = sum[2*BYTE_W-1:BYTE_W];

endmodule
